//--- sources.f
verilog/video_pkg.sv
verilog/dram_pkg.sv
verilog/frame_sync_decode.sv
verilog/pixel_convert.sv
verilog/burst_writer.sv
verilog/video_capture_top.sv
test/tb_video_capture.sv

//--- Makefile
TOP := tb_video_capture
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): sources.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

//--- test/tb_video_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_capture;

    localparam int BURST_LEN = 16;
    localparam int CLK_PERIOD_NS = 40;
    localparam int PIPE_LATENCY = 3;
    // Cycle budget of reset and the six tests in order
    localparam int TEST_CYCLES = 16 + 10 + 80 + 60 + 800 + 80 + 60;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD_NS;

    logic                    dvi2rgb_pixel_clk;
    logic                    rst_i;
    logic                    vsync_i;
    logic                    de_i;
    video_pkg::rgb_t         rgb_i;
    video_pkg::pixel_mode_e  pixel_mode_i;
    dram_pkg::wr_data_t      data_o;
    logic                    data_we_o;
    dram_pkg::wr_ctrl_t      ctrl_o;
    logic                    ctrl_we_o;
    logic                    frame_select_o;
    video_pkg::frame_count_t frame_count_o;

    // Expected and observed memory writes
    dram_pkg::wr_data_t exp_data[$];
    dram_pkg::wr_data_t got_data[$];
    dram_pkg::wr_ctrl_t exp_ctrl[$];
    dram_pkg::wr_ctrl_t got_ctrl[$];

    // Reference model of frame and burst state
    logic                    model_select;
    video_pkg::frame_count_t model_count;
    logic [31:0]             model_addr;
    int                      model_words;

    int seed;
    int data_errors;
    int ctrl_errors;
    int frame_errors;
    int other_errors;

    video_capture_top dut_i (
        .dvi2rgb_pixel_clk (dvi2rgb_pixel_clk),
        .rst_i             (rst_i),
        .vsync_i           (vsync_i),
        .de_i              (de_i),
        .rgb_i             (rgb_i),
        .pixel_mode_i      (pixel_mode_i),
        .data_o            (data_o),
        .data_we_o         (data_we_o),
        .ctrl_o            (ctrl_o),
        .ctrl_we_o         (ctrl_we_o),
        .frame_select_o    (frame_select_o),
        .frame_count_o     (frame_count_o)
    );

    initial begin
        dvi2rgb_pixel_clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) dvi2rgb_pixel_clk = ~dvi2rgb_pixel_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    // Collect every write strobe away from the active edge
    always @(negedge dvi2rgb_pixel_clk) begin
        if (!rst_i) begin
            if (data_we_o) begin
                got_data.push_back(data_o);
            end
            if (ctrl_we_o) begin
                got_ctrl.push_back(ctrl_o);
            end
        end
    end

    function automatic dram_pkg::wr_data_t expected_word(video_pkg::rgb_t px,
                                                         video_pkg::pixel_mode_e mode);
        dram_pkg::wr_data_t w;
        int sum;
        logic [7:0] y;
        sum = video_pkg::GRAY_R_WEIGHT * int'(px.red)
            + video_pkg::GRAY_G_WEIGHT * int'(px.green)
            + video_pkg::GRAY_B_WEIGHT * int'(px.blue);
        y = 8'(sum >> 8);
        if (mode == video_pkg::MODE_GRAY) begin
            w.data = {8'h00, y, y, y};
        end else begin
            w.data = {8'h00, px.red, px.green, px.blue};
        end
        w.strb = 4'b0111;
        return w;
    endfunction

    function automatic video_pkg::rgb_t random_pixel();
        logic [31:0] r;
        r = $random(seed);
        return r[23:0];
    endfunction

    task automatic model_word(video_pkg::rgb_t px, video_pkg::pixel_mode_e mode);
        dram_pkg::wr_ctrl_t cmd;
        exp_data.push_back(expected_word(px, mode));
        model_words++;
        if (model_words == BURST_LEN) begin
            cmd.len = 8'(BURST_LEN - 1);
            cmd.addr = model_addr;
            exp_ctrl.push_back(cmd);
            model_addr = model_addr + 32'(BURST_LEN * 4);
            model_words = 0;
        end
    endtask

    task automatic model_frame_start();
        dram_pkg::wr_ctrl_t cmd;
        // Open partial burst is closed at the old address
        if (model_words > 0) begin
            cmd.len = 8'(model_words - 1);
            cmd.addr = model_addr;
            exp_ctrl.push_back(cmd);
        end
        model_select = ~model_select;
        model_count = model_count + 4'd1;
        model_addr = model_select ? dram_pkg::FRAME0_BASE : dram_pkg::FRAME1_BASE;
        model_words = 0;
    endtask

    task automatic check_data(dram_pkg::wr_data_t exp, dram_pkg::wr_data_t got);
        if (got !== exp) begin
            data_errors++;
            $display("** Error data_o: expected 0x%h, got 0x%h", exp, got);
        end
    endtask

    task automatic check_ctrl(dram_pkg::wr_ctrl_t exp, dram_pkg::wr_ctrl_t got);
        if (got !== exp) begin
            ctrl_errors++;
            $display("** Error ctrl_o: expected 0x%h, got 0x%h", exp, got);
        end
    endtask

    task automatic check_frame(video_pkg::frame_count_t exp_count, logic exp_select);
        @(negedge dvi2rgb_pixel_clk);
        if (frame_count_o !== exp_count) begin
            frame_errors++;
            $display("** Error frame_count_o: expected 0x%h, got 0x%h",
                     exp_count, frame_count_o);
        end
        if (frame_select_o !== exp_select) begin
            frame_errors++;
            $display("** Error frame_select_o: expected 0x%h, got 0x%h",
                     exp_select, frame_select_o);
        end
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge dvi2rgb_pixel_clk);
            de_i <= 1'b0;
        end
    endtask

    task automatic send_pixel(video_pkg::rgb_t px, video_pkg::pixel_mode_e mode);
        @(posedge dvi2rgb_pixel_clk);
        de_i         <= 1'b1;
        rgb_i        <= px;
        pixel_mode_i <= mode;
        model_word(px, mode);
    endtask

    // Blanking around the pulse keeps de_i low as callers must
    task automatic send_vsync();
        idle(2);
        @(posedge dvi2rgb_pixel_clk);
        vsync_i <= 1'b1;
        de_i    <= 1'b0;
        idle(3);
        @(posedge dvi2rgb_pixel_clk);
        vsync_i <= 1'b0;
        idle(3);
        model_frame_start();
        check_frame(model_count, model_select);
    endtask

    task automatic compare_results(string test_name);
        int waited;
        dram_pkg::wr_data_t exp_w;
        dram_pkg::wr_data_t got_w;
        dram_pkg::wr_ctrl_t exp_c;
        dram_pkg::wr_ctrl_t got_c;
        waited = 0;
        idle(1);
        while ((got_data.size() < exp_data.size() || got_ctrl.size() < exp_ctrl.size())
               && waited < 40) begin
            @(negedge dvi2rgb_pixel_clk);
            waited++;
        end
        // Late extra writes still fall within the pipeline depth
        repeat (6) @(negedge dvi2rgb_pixel_clk);
        while (exp_data.size() > 0 && got_data.size() > 0) begin
            exp_w = exp_data.pop_front();
            got_w = got_data.pop_front();
            check_data(exp_w, got_w);
        end
        while (exp_ctrl.size() > 0 && got_ctrl.size() > 0) begin
            exp_c = exp_ctrl.pop_front();
            got_c = got_ctrl.pop_front();
            check_ctrl(exp_c, got_c);
        end
        if (exp_data.size() > 0) begin
            other_errors++;
            $display("%s: %0d expected data words were never written",
                     test_name, exp_data.size());
        end
        if (got_data.size() > 0) begin
            other_errors++;
            $display("%s: %0d unexpected data words were written", test_name, got_data.size());
        end
        if (exp_ctrl.size() > 0) begin
            other_errors++;
            $display("%s: %0d expected burst commands never appeared",
                     test_name, exp_ctrl.size());
        end
        if (got_ctrl.size() > 0) begin
            other_errors++;
            $display("%s: %0d unexpected burst commands appeared", test_name, got_ctrl.size());
        end
        exp_data.delete();
        got_data.delete();
        exp_ctrl.delete();
        got_ctrl.delete();
    endtask

    task automatic test_reset_values();
        repeat (4) @(negedge dvi2rgb_pixel_clk);
        if (data_we_o !== 1'b0) begin
            other_errors++;
            $display("** Error data_we_o: expected 0x0, got 0x%h", data_we_o);
        end
        if (ctrl_we_o !== 1'b0) begin
            other_errors++;
            $display("** Error ctrl_we_o: expected 0x0, got 0x%h", ctrl_we_o);
        end
        check_frame(4'd0, 1'b0);
        compare_results("reset values");
    endtask

    task automatic test_rgb_bursts();
        send_vsync();
        for (int i = 0; i < 32; i++) begin
            send_pixel(random_pixel(), video_pkg::MODE_RGB);
        end
        compare_results("rgb bursts");
    endtask

    task automatic test_grayscale();
        send_pixel(24'hffffff, video_pkg::MODE_GRAY);
        send_pixel(24'h000000, video_pkg::MODE_GRAY);
        for (int i = 0; i < 10; i++) begin
            send_pixel(random_pixel(), video_pkg::MODE_GRAY);
        end
        // Mixed modes within one line
        for (int i = 0; i < 6; i++) begin
            send_pixel(random_pixel(), (i % 2 == 1) ? video_pkg::MODE_GRAY
                                                    : video_pkg::MODE_RGB);
        end
        compare_results("grayscale");
    endtask

    task automatic test_frame_start();
        // Enough frames to wrap the counter
        for (int f = 0; f < 17; f++) begin
            send_vsync();
            for (int i = 0; i < BURST_LEN; i++) begin
                send_pixel(random_pixel(), video_pkg::MODE_RGB);
            end
            compare_results("frame start");
        end
    endtask

    task automatic test_partial_flush();
        for (int i = 0; i < 5; i++) begin
            send_pixel(random_pixel(), video_pkg::MODE_RGB);
        end
        send_vsync();
        for (int i = 0; i < BURST_LEN; i++) begin
            send_pixel(random_pixel(), video_pkg::MODE_RGB);
        end
        compare_results("partial flush");
    endtask

    task automatic test_latency();
        int first_de;
        int first_we;
        int last_we;
        int de_cycles;
        int we_cycles;
        first_de = -1;
        first_we = -1;
        last_we = -1;
        de_cycles = 0;
        we_cycles = 0;
        for (int i = 0; i < 30; i++) begin
            if (i < 20) begin
                send_pixel(random_pixel(), video_pkg::MODE_RGB);
            end else begin
                idle(1);
            end
            @(negedge dvi2rgb_pixel_clk);
            if (de_i) begin
                de_cycles++;
                if (first_de < 0) begin
                    first_de = i;
                end
            end
            if (data_we_o) begin
                we_cycles++;
                if (first_we < 0) begin
                    first_we = i;
                end
                last_we = i;
            end
        end
        if (first_we < 0 || first_we - first_de != PIPE_LATENCY) begin
            other_errors++;
            $display("data_we_o rose %0d cycles after de_i instead of %0d",
                     first_we - first_de, PIPE_LATENCY);
        end
        if (we_cycles != de_cycles || last_we - first_we + 1 != de_cycles) begin
            other_errors++;
            $display("data_we_o was not high for one unbroken run of %0d cycles", de_cycles);
        end
        compare_results("latency");
    endtask

    initial begin
        seed = 32'hcac7;
        data_errors = 0;
        ctrl_errors = 0;
        frame_errors = 0;
        other_errors = 0;
        rst_i = 1'b1;
        vsync_i = 1'b0;
        de_i = 1'b0;
        rgb_i = '0;
        pixel_mode_i = video_pkg::MODE_RGB;
        model_select = 1'b0;
        model_count = '0;
        model_addr = dram_pkg::FRAME1_BASE;
        model_words = 0;
        repeat (16) @(posedge dvi2rgb_pixel_clk);
        rst_i <= 1'b0;

        test_reset_values();
        test_rgb_bursts();
        test_grayscale();
        test_frame_start();
        test_partial_flush();
        test_latency();

        $display("Errors: data %0d, ctrl %0d, frame %0d, other %0d",
                 data_errors, ctrl_errors, frame_errors, other_errors);
        if (data_errors + ctrl_errors + frame_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/video_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_capture_top #(
    parameter int BURST_LEN = 16
) (
    input  wire                         dvi2rgb_pixel_clk,
    input  wire                         rst_i,
    input  wire                         vsync_i,
    input  wire                         de_i,
    input  wire video_pkg::rgb_t        rgb_i,
    input  wire video_pkg::pixel_mode_e pixel_mode_i,
    output wire dram_pkg::wr_data_t     data_o,
    output wire                         data_we_o,
    output wire dram_pkg::wr_ctrl_t     ctrl_o,
    output wire                         ctrl_we_o,
    output wire                         frame_select_o,
    output wire video_pkg::frame_count_t frame_count_o
);

    // Decode to execute
    wire                         pix_valid;
    wire video_pkg::rgb_t        pix_rgb;
    wire video_pkg::pixel_mode_e pix_mode;
    wire                         frame_start;

    // Execute to result
    wire                         word_valid;
    wire dram_pkg::wr_data_t     word;
    wire                         word_frame_start;

    frame_sync_decode u_decode (
        .dvi2rgb_pixel_clk (dvi2rgb_pixel_clk),
        .rst_i             (rst_i),
        .vsync_i           (vsync_i),
        .de_i              (de_i),
        .rgb_i             (rgb_i),
        .pixel_mode_i      (pixel_mode_i),
        .pix_valid_o       (pix_valid),
        .pix_rgb_o         (pix_rgb),
        .pix_mode_o        (pix_mode),
        .frame_start_o     (frame_start),
        .frame_select_o    (frame_select_o),
        .frame_count_o     (frame_count_o)
    );

    pixel_convert u_convert (
        .dvi2rgb_pixel_clk  (dvi2rgb_pixel_clk),
        .rst_i              (rst_i),
        .pix_valid_i        (pix_valid),
        .pix_rgb_i          (pix_rgb),
        .pix_mode_i         (pix_mode),
        .frame_start_i      (frame_start),
        .word_valid_o       (word_valid),
        .word_o             (word),
        .word_frame_start_o (word_frame_start)
    );

    // Buffer select goes straight to the writer as a level
    burst_writer #(
        .BURST_LEN (BURST_LEN)
    ) u_writer (
        .dvi2rgb_pixel_clk (dvi2rgb_pixel_clk),
        .rst_i             (rst_i),
        .word_valid_i      (word_valid),
        .word_i            (word),
        .frame_start_i     (word_frame_start),
        .frame_select_i    (frame_select_o),
        .data_o            (data_o),
        .data_we_o         (data_we_o),
        .ctrl_o            (ctrl_o),
        .ctrl_we_o         (ctrl_we_o)
    );

endmodule

`default_nettype wire

//--- verilog/burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_writer #(
    parameter int BURST_LEN = 16
) (
    input  wire                     dvi2rgb_pixel_clk,
    input  wire                     rst_i,
    input  wire                     word_valid_i,
    input  wire dram_pkg::wr_data_t word_i,
    input  wire                     frame_start_i,
    input  wire                     frame_select_i,
    output dram_pkg::wr_data_t      data_o,
    output logic                    data_we_o,
    output dram_pkg::wr_ctrl_t      ctrl_o,
    output logic                    ctrl_we_o
);

    localparam int ADDR_W = dram_pkg::ADDR_W;
    localparam int LEN_W  = dram_pkg::LEN_W;

    // Counter holds the words already in the open burst
    localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
    localparam logic [CNT_W-1:0]  LAST_WORD  = CNT_W'(BURST_LEN - 1);
    localparam logic [LEN_W-1:0]  FULL_LEN   = LEN_W'(BURST_LEN - 1);
    localparam logic [ADDR_W-1:0] BURST_STEP = ADDR_W'(BURST_LEN * dram_pkg::BYTES_PER_WORD);

    dram_pkg::writer_state_e state;
    logic [CNT_W-1:0]        word_cnt;
    logic [ADDR_W-1:0]       burst_addr;
    logic [ADDR_W-1:0]       frame_base;

    logic                    burst_full;
    logic                    burst_flush;
    logic [LEN_W-1:0]        cmd_len;

    // Select 1 maps to frame 0
    assign frame_base = frame_select_i ? dram_pkg::FRAME0_BASE : dram_pkg::FRAME1_BASE;

    // Last word of a full burst
    assign burst_full = word_valid_i && !frame_start_i && (word_cnt == LAST_WORD);

    // Partial burst left open when a new frame begins
    assign burst_flush = frame_start_i && (state == dram_pkg::ST_FILLING);

    assign cmd_len = burst_flush ? LEN_W'(word_cnt - CNT_W'(1)) : FULL_LEN;

    // Burst FSM and address tracking
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        if (rst_i) begin
            state      <= dram_pkg::ST_EMPTY;
            word_cnt   <= '0;
            burst_addr <= dram_pkg::FRAME1_BASE;
            data_we_o  <= 1'b0;
            ctrl_we_o  <= 1'b0;
        end else begin
            data_we_o <= word_valid_i;
            ctrl_we_o <= burst_full || burst_flush;
            if (frame_start_i) begin
                // Restart at the base of the new frame
                state      <= dram_pkg::ST_EMPTY;
                word_cnt   <= '0;
                burst_addr <= frame_base;
            end else if (word_valid_i) begin
                if (burst_full) begin
                    state      <= dram_pkg::ST_EMPTY;
                    word_cnt   <= '0;
                    burst_addr <= burst_addr + BURST_STEP;
                end else begin
                    state    <= dram_pkg::ST_FILLING;
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Data and command payloads
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        data_o <= word_i;
        if (burst_full || burst_flush) begin
            ctrl_o.len  <= cmd_len;
            ctrl_o.addr <= burst_addr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_convert.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_convert (
    input  wire                         dvi2rgb_pixel_clk,
    input  wire                         rst_i,
    input  wire                         pix_valid_i,
    input  wire video_pkg::rgb_t        pix_rgb_i,
    input  wire video_pkg::pixel_mode_e pix_mode_i,
    input  wire                         frame_start_i,
    output logic                        word_valid_o,
    output dram_pkg::wr_data_t          word_o,
    output logic                        word_frame_start_o
);

    localparam int COLOR_W = video_pkg::COLOR_W;
    localparam int SUM_W   = video_pkg::LUMA_SUM_W;

    logic [SUM_W-1:0]           luma_sum;
    logic [COLOR_W-1:0]         luma;
    logic [dram_pkg::DATA_W-1:0] word_data;

    // Weighted sum of the three channels
    assign luma_sum = SUM_W'(video_pkg::GRAY_R_WEIGHT) * SUM_W'(pix_rgb_i.red)
                    + SUM_W'(video_pkg::GRAY_G_WEIGHT) * SUM_W'(pix_rgb_i.green)
                    + SUM_W'(video_pkg::GRAY_B_WEIGHT) * SUM_W'(pix_rgb_i.blue);

    // Divide by 256
    assign luma = luma_sum[SUM_W-1:SUM_W-COLOR_W];

    // Mode decode, top byte stays zero
    always_comb begin
        case (pix_mode_i)
            video_pkg::MODE_GRAY: begin
                word_data = {8'h00, luma, luma, luma};
            end
            default: begin
                word_data = {8'h00, pix_rgb_i};
            end
        endcase
    end

    // Control strobes
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        if (rst_i) begin
            word_valid_o       <= 1'b0;
            word_frame_start_o <= 1'b0;
        end else begin
            word_valid_o       <= pix_valid_i;
            // Keeps frame start in step with the pixel pipeline
            word_frame_start_o <= frame_start_i;
        end
    end

    // Word payload with strobe appended
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        word_o.data <= word_data;
        word_o.strb <= dram_pkg::PIXEL_STRB;
    end

endmodule

`default_nettype wire

//--- verilog/frame_sync_decode.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sync_decode (
    input  wire                        dvi2rgb_pixel_clk,
    input  wire                        rst_i,
    input  wire                        vsync_i,
    input  wire                        de_i,
    input  wire video_pkg::rgb_t       rgb_i,
    input  wire video_pkg::pixel_mode_e pixel_mode_i,
    output logic                       pix_valid_o,
    output video_pkg::rgb_t            pix_rgb_o,
    output video_pkg::pixel_mode_e     pix_mode_o,
    output logic                       frame_start_o,
    output logic                       frame_select_o,
    output video_pkg::frame_count_t    frame_count_o
);

    // Registered vsync and its previous value
    logic vsync_q;
    logic vsync_qq;
    logic vsync_rise;

    assign vsync_rise = vsync_q & ~vsync_qq;

    // Pixel strobe
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        if (rst_i) begin
            pix_valid_o <= 1'b0;
        end else begin
            pix_valid_o <= de_i;
        end
    end

    // Pixel value and mode travel with the strobe
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        pix_rgb_o  <= rgb_i;
        pix_mode_o <= pixel_mode_i;
    end

    // Vsync edge detection
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        if (rst_i) begin
            vsync_q  <= 1'b0;
            vsync_qq <= 1'b0;
        end else begin
            vsync_q  <= vsync_i;
            vsync_qq <= vsync_q;
        end
    end

    // Frame start pulse, frame counter and buffer select
    always_ff @(posedge dvi2rgb_pixel_clk) begin
        if (rst_i) begin
            frame_start_o  <= 1'b0;
            frame_select_o <= 1'b0;
            frame_count_o  <= '0;
        end else begin
            frame_start_o <= vsync_rise;
            if (vsync_rise) begin
                // Counter wraps after 15
                frame_count_o  <= frame_count_o + 1'b1;
                frame_select_o <= ~frame_select_o;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dram_pkg.sv
`default_nettype none

package dram_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // Burst length field of a command, holds length minus one
    localparam int LEN_W = 8;

    // Write data word with its byte strobe in the low bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_data_t;

    // Burst command, length minus one above the start address
    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } wr_ctrl_t;

    // Double buffer base addresses
    localparam logic [ADDR_W-1:0] FRAME0_BASE = 32'h0;
    localparam logic [ADDR_W-1:0] FRAME1_BASE = 32'h100_0000;

    // Only the three color bytes are written
    localparam logic [STRB_W-1:0] PIXEL_STRB = 4'b0111;

    localparam int BYTES_PER_WORD = 4;

    typedef enum logic {
        ST_EMPTY   = 1'b0,
        ST_FILLING = 1'b1
    } writer_state_e;

endpackage

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // Bits per color channel
    localparam int COLOR_W = 8;

    // Frame counter width
    localparam int FRAME_COUNT_W = 4;

    // One received pixel, red in the top byte
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } rgb_t;

    // How a pixel is written to frame memory
    typedef enum logic {
        MODE_RGB  = 1'b0,
        MODE_GRAY = 1'b1
    } pixel_mode_e;

    typedef logic [FRAME_COUNT_W-1:0] frame_count_t;

    // Luma weights, they add up to 256 so a shift by 8 normalizes
    localparam int GRAY_R_WEIGHT = 77;
    localparam int GRAY_G_WEIGHT = 150;
    localparam int GRAY_B_WEIGHT = 29;

    // Width of the weighted sum before the shift
    localparam int LUMA_SUM_W = 2 * COLOR_W;

endpackage

`default_nettype wire
